// ==== source/stat_pkg.sv ====
// Statistics counter package with counter, address and event types
package stat_pkg;

    // Counter index, 32 counters
    typedef logic [4:0] stat_addr_t;

    // Counter value
    typedef logic [31:0] stat_cnt_t;

    // Event amount
    typedef logic [15:0] stat_amt_t;

    // Event operation
    typedef enum logic [1:0] {
        STAT_ADD = 2'd0,
        STAT_SUB = 2'd1,
        STAT_CLR = 2'd2,
        STAT_NOP = 2'd3
    } stat_op_e;

    // Incoming event, 23 bits
    typedef struct packed {
        stat_op_e   op;
        stat_addr_t addr;
        stat_amt_t  amt;
    } stat_event_t;

    // Update report, 38 bits
    typedef struct packed {
        stat_addr_t addr;
        stat_cnt_t  value;
        logic       sat;
    } stat_report_t;

    // Counter RAM read latency in cycles
    localparam int STAT_RD_LAT = 3;

endpackage

// ==== source/stat_event_in.sv ====
// Event intake that registers incoming events and issues counter reads
module stat_event_in
    import stat_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        ev_valid,
    input  stat_event_t ev,
    output logic        rd_en,
    output stat_addr_t  rd_addr,
    output stat_event_t ev_q
);

    logic       take;
    stat_op_e   op_q;
    stat_addr_t addr_q;
    stat_amt_t  amt_q;

    // Only valid events with a real operation touch the RAM
    assign take = ev_valid && (ev.op != STAT_NOP);

    ////////////////////
    // Control register

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_en <= 1'b0;
            op_q  <= STAT_NOP;
        end
        else
        begin
            rd_en <= take;
            // Dropped slots become NOP so later stages skip them
            op_q  <= take ? ev.op : STAT_NOP;
        end
    end

    // Payload register
    always_ff @(posedge clk)
    begin
        addr_q <= ev.addr;
        amt_q  <= ev.amt;
    end

    assign rd_addr = addr_q;
    assign ev_q    = '{op: op_q, addr: addr_q, amt: amt_q};

    // Event fields must be known whenever the source marks them valid
    a_ev_known: assert property (@(posedge clk) disable iff (rst) ev_valid |-> !$isunknown(ev))
        else $error("event carries X while ev_valid is high");

endmodule

// ==== source/stat_rmw_conflict.sv ====
// Read-modify-write pipeline with write conflict detection and data forwarding
module stat_rmw_conflict
    import stat_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rd_en,
    input  stat_addr_t rd_addr,
    output stat_cnt_t  old_cnt,
    input  stat_cnt_t  new_cnt,
    output logic       mem_we,
    output stat_addr_t mem_wa,
    output stat_cnt_t  mem_wd,
    output logic       mem_re,
    output stat_addr_t mem_ra,
    input  stat_cnt_t  mem_rd
);

    // Write-back stage, one past the read data stage
    localparam int WR_STG = STAT_RD_LAT + 1;

    logic [WR_STG:1] re_q;
    stat_addr_t      ra_q [1:WR_STG];
    logic            hit_s0;
    logic            hit_s1;
    logic            hit_s2;
    logic            fwd_s1;
    logic            fwd_s2;
    logic            fwd_s3;
    logic            adj_s3;
    stat_cnt_t       fwd_d1;
    stat_cnt_t       fwd_d2;
    stat_cnt_t       fwd_d3;

    ////////////////////
    // Stage pipeline

    always_ff @(posedge clk)
    begin
        if (rst)
            re_q <= '0;
        else
            re_q <= {re_q[WR_STG-1:1], rd_en};
    end

    always_ff @(posedge clk)
    begin
        ra_q[1] <= rd_addr;
        for (int i = 2; i <= WR_STG; i++)
            ra_q[i] <= ra_q[i-1];
    end

    // Write back at the last stage
    assign mem_we = re_q[WR_STG];
    assign mem_wa = ra_q[WR_STG];
    assign mem_wd = new_cnt;

    ////////////////////
    // Conflict detection

    // Write against the address sitting at stages 0, 1 and 2
    assign hit_s0 = mem_we && (mem_wa == rd_addr);
    assign hit_s1 = mem_we && (mem_wa == ra_q[1]);
    assign hit_s2 = mem_we && (mem_wa == ra_q[2]);

    // Same-cycle read of the written address is dropped, data comes from the write path
    assign mem_re = rd_en && !hit_s0;
    assign mem_ra = rd_addr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fwd_s1 <= 1'b0;
            fwd_s2 <= 1'b0;
            fwd_s3 <= 1'b0;
            adj_s3 <= 1'b0;
        end
        else
        begin
            fwd_s1 <= rd_en && hit_s0;
            fwd_s2 <= fwd_s1 || hit_s1;
            fwd_s3 <= fwd_s2 || hit_s2;
            // Stages 2 and 3 now become the stage 3/4 pair next cycle
            adj_s3 <= re_q[2] && re_q[3] && (ra_q[2] == ra_q[3]);
        end
    end

    // Forwarded write data follows its event, a newer write replaces it
    always_ff @(posedge clk)
    begin
        fwd_d1 <= mem_wd;
        fwd_d2 <= hit_s1 ? mem_wd : fwd_d1;
        fwd_d3 <= hit_s2 ? mem_wd : fwd_d2;
    end

    // Newest value wins: stage 4 result, then forwarded data, then RAM
    assign old_cnt = adj_s3 ? new_cnt :
                     fwd_s3 ? fwd_d3  : mem_rd;

    a_no_rw_same_addr: assert property (@(posedge clk) disable iff (rst)
        (mem_we && mem_re) |-> (mem_wa != mem_ra))
        else $error("RAM read and write hit one address in one cycle");

    // Forwarding taps above assume exactly three read stages
    a_rd_lat: assert property (@(posedge clk) STAT_RD_LAT == 3)
        else $error("read latency differs from the forwarding structure");

endmodule

// ==== source/stat_ram.sv ====
// Counter RAM with one write port and a three-cycle read port
module stat_ram
    import stat_pkg::*;
(
    input  logic       clk,
    input  logic       we,
    input  stat_addr_t wa,
    input  stat_cnt_t  wd,
    input  logic       re,
    input  stat_addr_t ra,
    output stat_cnt_t  rd
);

    localparam int DEPTH = 2 ** $bits(stat_addr_t);

    stat_cnt_t mem     [DEPTH];
    stat_cnt_t rd_pipe [1:STAT_RD_LAT];

    // All counters start at zero
    initial
    begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = '0;
    end

    ////////////////////
    // Write port

    always_ff @(posedge clk)
    begin
        if (we)
            mem[wa] <= wd;
    end

    ////////////////////
    // Read port

    // Registered read, then output pipeline
    always_ff @(posedge clk)
    begin
        if (re)
            rd_pipe[1] <= mem[ra];
        for (int i = 2; i <= STAT_RD_LAT; i++)
            rd_pipe[i] <= rd_pipe[i-1];
    end

    assign rd = rd_pipe[STAT_RD_LAT];

endmodule

// ==== source/stat_update.sv ====
// Counter update stage that computes saturating add, subtract and clear
module stat_update
    import stat_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  stat_event_t  ev_q,
    input  stat_cnt_t    old_cnt,
    output stat_cnt_t    new_cnt,
    output logic         upd_valid,
    output stat_report_t upd
);

    stat_op_e   op_d   [1:STAT_RD_LAT];
    stat_addr_t addr_d [1:STAT_RD_LAT];
    stat_amt_t  amt_d  [1:STAT_RD_LAT];
    stat_cnt_t  amt_ext;
    logic [$bits(stat_cnt_t):0] sum;
    stat_cnt_t  calc;
    logic       calc_sat;

    ////////////////////
    // Delay to data stage

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i <= STAT_RD_LAT; i++)
                op_d[i] <= STAT_NOP;
        end
        else
        begin
            op_d[1] <= ev_q.op;
            for (int i = 2; i <= STAT_RD_LAT; i++)
                op_d[i] <= op_d[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        addr_d[1] <= ev_q.addr;
        amt_d[1]  <= ev_q.amt;
        for (int i = 2; i <= STAT_RD_LAT; i++)
        begin
            addr_d[i] <= addr_d[i-1];
            amt_d[i]  <= amt_d[i-1];
        end
    end

    ////////////////////
    // Arithmetic

    assign amt_ext = stat_cnt_t'(amt_d[STAT_RD_LAT]);
    // Extra top bit flags overflow
    assign sum     = {1'b0, old_cnt} + {1'b0, amt_ext};

    always_comb
    begin
        calc     = old_cnt;
        calc_sat = 1'b0;
        case (op_d[STAT_RD_LAT])
            STAT_ADD:
            begin
                calc     = sum[$bits(stat_cnt_t)] ? '1 : sum[$bits(stat_cnt_t)-1:0];
                calc_sat = sum[$bits(stat_cnt_t)];
            end
            STAT_SUB:
            begin
                // Floor at zero
                calc     = (amt_ext > old_cnt) ? '0 : old_cnt - amt_ext;
                calc_sat = (amt_ext > old_cnt);
            end
            STAT_CLR:
                calc = '0;
            default:
                calc = old_cnt;
        endcase
    end

    // Stage 4 result register
    always_ff @(posedge clk)
    begin
        if (rst)
            upd_valid <= 1'b0;
        else
            upd_valid <= (op_d[STAT_RD_LAT] != STAT_NOP);
    end

    always_ff @(posedge clk)
    begin
        new_cnt <= calc;
        upd     <= '{addr: addr_d[STAT_RD_LAT], value: calc, sat: calc_sat};
    end

endmodule

// ==== source/stat_report.sv ====
// Report stage that streams counter updates and counts saturations
module stat_report
    import stat_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         upd_valid,
    input  stat_report_t upd,
    output logic         rep_valid,
    output stat_report_t rep,
    output stat_cnt_t    sat_count
);

    logic sat_hit;

    // Saturated update, counter held once it reaches all-ones
    assign sat_hit = upd_valid && upd.sat && (sat_count != '1);

    ////////////////////
    // Output stream

    always_ff @(posedge clk)
    begin
        if (rst)
            rep_valid <= 1'b0;
        else
            rep_valid <= upd_valid;
    end

    // Report payload
    always_ff @(posedge clk)
    begin
        rep <= upd;
    end

    ////////////////////
    // Saturation count

    always_ff @(posedge clk)
    begin
        if (rst)
            sat_count <= '0;
        else if (sat_hit)
            sat_count <= sat_count + 1'b1;
    end

endmodule

// ==== source/stat_top.sv ====
// Statistics counter top level joining intake, RMW pipeline, RAM and report
module stat_top
    import stat_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         ev_valid,
    input  stat_event_t  ev,
    output logic         rep_valid,
    output stat_report_t rep,
    output stat_cnt_t    sat_count
);

    // Intake to pipeline
    logic         rd_en;
    stat_addr_t   rd_addr;
    stat_event_t  ev_q;

    // Resolver and update
    stat_cnt_t    old_cnt;
    stat_cnt_t    new_cnt;

    // RAM ports
    logic         mem_we;
    stat_addr_t   mem_wa;
    stat_cnt_t    mem_wd;
    logic         mem_re;
    stat_addr_t   mem_ra;
    stat_cnt_t    mem_rd;

    // Update to report
    logic         upd_valid;
    stat_report_t upd;

    stat_event_in i_event_in (
        .clk      (clk),
        .rst      (rst),
        .ev_valid (ev_valid),
        .ev       (ev),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .ev_q     (ev_q)
    );

    stat_rmw_conflict i_conflict (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .old_cnt  (old_cnt),
        .new_cnt  (new_cnt),
        .mem_we   (mem_we),
        .mem_wa   (mem_wa),
        .mem_wd   (mem_wd),
        .mem_re   (mem_re),
        .mem_ra   (mem_ra),
        .mem_rd   (mem_rd)
    );

    stat_ram i_ram (
        .clk (clk),
        .we  (mem_we),
        .wa  (mem_wa),
        .wd  (mem_wd),
        .re  (mem_re),
        .ra  (mem_ra),
        .rd  (mem_rd)
    );

    stat_update i_update (
        .clk       (clk),
        .rst       (rst),
        .ev_q      (ev_q),
        .old_cnt   (old_cnt),
        .new_cnt   (new_cnt),
        .upd_valid (upd_valid),
        .upd       (upd)
    );

    stat_report i_report (
        .clk       (clk),
        .rst       (rst),
        .upd_valid (upd_valid),
        .upd       (upd),
        .rep_valid (rep_valid),
        .rep       (rep),
        .sat_count (sat_count)
    );

endmodule

// ==== verif/stat_tb.sv ====
// Statistics counter testbench with LCG stimulus, reference model and report checker
module stat_tb
    import stat_pkg::*;
();

    // Expected report with its sat_count and the cycle its event was driven
    typedef struct packed {
        stat_report_t rep;
        stat_cnt_t    sat_cnt;
        logic [31:0]  cyc;
    } exp_entry_t;

    logic         clk;
    logic         rst;
    logic         ev_valid;
    stat_event_t  ev;
    logic         rep_valid;
    stat_report_t rep;
    stat_cnt_t    sat_count;

    logic [31:0]  cyc;
    logic [31:0]  lcg_state;
    stat_cnt_t    model_cnt [32];
    stat_cnt_t    model_sat;
    exp_entry_t   exp_q [$];
    exp_entry_t   got_exp;

    stat_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .ev_valid  (ev_valid),
        .ev        (ev),
        .rep_valid (rep_valid),
        .rep       (rep),
        .sat_count (sat_count)
    );

    always #10 clk = ~clk;

    // Cycle count used for the latency check
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    ////////////////////
    // Helpers

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp)
        begin
            stop_on_error($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Reference model: apply one event to the counter array
    function automatic exp_entry_t apply_event(input stat_event_t e);
        exp_entry_t  r;
        stat_cnt_t   old;
        old = model_cnt[e.addr];
        r.rep.addr = e.addr;
        r.rep.sat  = 1'b0;
        r.rep.value = old;
        if (e.op == STAT_ADD)
        begin
            // Headroom left below all-ones decides saturation
            r.rep.sat   = ({16'b0, e.amt} > (32'hffff_ffff - old));
            r.rep.value = r.rep.sat ? 32'hffff_ffff : old + {16'b0, e.amt};
        end
        else if (e.op == STAT_SUB)
        begin
            r.rep.sat   = (old < {16'b0, e.amt});
            r.rep.value = r.rep.sat ? 32'h0 : old - {16'b0, e.amt};
        end
        else if (e.op == STAT_CLR)
            r.rep.value = 32'h0;
        model_cnt[e.addr] = r.rep.value;
        if (r.rep.sat && model_sat != 32'hffff_ffff)
            model_sat++;
        r.sat_cnt = model_sat;
        r.cyc     = cyc;
        return r;
    endfunction

    task automatic send_event(input stat_op_e op, input stat_addr_t addr,
                              input stat_amt_t amt);
        stat_event_t e;
        e = '{op: op, addr: addr, amt: amt};
        @(negedge clk);
        ev_valid = 1'b1;
        ev       = e;
        if (op != STAT_NOP)
            exp_q.push_back(apply_event(e));
    endtask

    // Invalid slot, payload left as junk
    task automatic drive_idle();
        logic [31:0] junk;
        junk = lcg_next();
        @(negedge clk);
        ev_valid = 1'b0;
        ev       = junk[22:0];
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0)
            stop_on_error("Timed out waiting for outstanding reports to arrive");
    endtask

    // Random op weighted towards ADD and SUB
    function automatic stat_op_e pick_op(input logic [2:0] sel);
        if (sel < 3'd4)
            return STAT_ADD;
        else if (sel < 3'd7)
            return STAT_SUB;
        return STAT_CLR;
    endfunction

    ////////////////////
    // Report checker

    always @(negedge clk)
    begin
        if (!rst && rep_valid)
        begin
            if (exp_q.size() == 0)
                stop_on_error("Report arrived while no event was outstanding");
            else
            begin
                got_exp = exp_q.pop_front();
                compare_value("rep.addr", rep.addr, got_exp.rep.addr);
                compare_value("rep.value", rep.value, got_exp.rep.value);
                compare_value("rep.sat", rep.sat, got_exp.rep.sat);
                compare_value("sat_count", sat_count, got_exp.sat_cnt);
                compare_value("rep_latency", cyc - got_exp.cyc, 64'd6);
            end
        end
    end

    ////////////////////
    // Stimulus

    initial
    begin
        logic [31:0] r;
        logic [31:0] s;
        clk       = 1'b0;
        rst       = 1'b1;
        ev_valid  = 1'b0;
        ev        = '0;
        cyc       = '0;
        lcg_state = 32'hae9e;
        model_sat = '0;
        for (int i = 0; i < 32; i++)
            model_cnt[i] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Quiet output straight after reset
        repeat (4)
        begin
            drive_idle();
            compare_value("rep_valid", rep_valid, 64'd0);
            compare_value("sat_count", sat_count, 64'd0);
        end

        // Back-to-back random events on random counters
        for (int i = 0; i < 300; i++)
        begin
            r = lcg_next();
            s = lcg_next();
            send_event(pick_op(r[26:24]), r[31:27], s[31:16]);
        end

        // Same counter with every gap length, hits each forwarding path
        for (int gap = 0; gap <= 4; gap++)
        begin
            for (int i = 0; i < 10; i++)
            begin
                r = lcg_next();
                send_event((r[31:30] == 2'd0) ? STAT_SUB : STAT_ADD, 5'd12,
                           {4'h0, r[19:8]});
                repeat (gap) drive_idle();
            end
        end

        // Walk counter 7 up to all-ones, then past it
        send_event(STAT_CLR, 5'd7, 16'h0);
        for (int i = 0; i < 65540; i++)
            send_event(STAT_ADD, 5'd7, 16'hffff);

        // Underflow on counter 20
        send_event(STAT_CLR, 5'd20, 16'h0);
        send_event(STAT_ADD, 5'd20, 16'd3);
        send_event(STAT_SUB, 5'd20, 16'hffff);
        send_event(STAT_SUB, 5'd20, 16'd1);

        // Clear then add at once
        send_event(STAT_ADD, 5'd9, 16'd100);
        send_event(STAT_CLR, 5'd9, 16'h0);
        send_event(STAT_ADD, 5'd9, 16'h1234);

        // NOPs and invalid slots mixed with real events
        for (int i = 0; i < 60; i++)
        begin
            r = lcg_next();
            if (r[1:0] == 2'd0)
                drive_idle();
            else if (r[1:0] == 2'd1)
                send_event(STAT_NOP, r[31:27], r[23:8]);
            else
                send_event(pick_op(r[26:24]), r[31:27], r[23:8]);
        end

        drive_idle();
        wait_drain(50);
        // Stray reports after the drain would trip the checker here
        repeat (12) drive_idle();

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== tb.f ====
source/stat_pkg.sv
source/stat_event_in.sv
source/stat_rmw_conflict.sv
source/stat_ram.sv
source/stat_update.sv
source/stat_report.sv
source/stat_top.sv
verif/stat_tb.sv

// ==== Bender.yml ====
package:
  name: stat_counter

sources:
  - source/stat_pkg.sv
  - source/stat_event_in.sv
  - source/stat_rmw_conflict.sv
  - source/stat_ram.sv
  - source/stat_update.sv
  - source/stat_report.sv
  - source/stat_top.sv
  - target: test
    files:
      - verif/stat_tb.sv
